// File: hdl/axil_router_pkg.sv
package axil_router_pkg;

  // manager side address and the slice handed to each subordinate
  localparam int addr_w     = 16;
  localparam int sub_addr_w = 14;

  // data path is the same width on both sides
  localparam int data_w = 32;
  localparam int strb_w = data_w / 8;

  // address map: bits 15:14 pick the subordinate, value 3 is unmapped
  localparam int num_sub = 3;
  localparam int sel_w   = 2;
  localparam int sel_lsb = sub_addr_w;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_exokay = 2'b01,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } resp_e;

  typedef enum logic [1:0] {
    wr_idle   = 2'd0,
    wr_fwd    = 2'd1,
    wr_wait_b = 2'd2,
    wr_resp   = 2'd3
  } wr_state_e;

  typedef enum logic [1:0] {
    rd_idle   = 2'd0,
    rd_fwd    = 2'd1,
    rd_wait_r = 2'd2,
    rd_resp   = 2'd3
  } rd_state_e;

endpackage

// File: hdl/axil_addr_decode.sv
`timescale 1ns/1ps

module axil_addr_decode
  import axil_router_pkg::*;
(
  input  logic [addr_w-1:0]     addr,
  output logic [sel_w-1:0]      sel,
  output logic                  dec_err,
  output logic [sub_addr_w-1:0] local_addr
);

  logic [sel_w-1:0] idx;

  // top address bits form the subordinate index
  assign idx = addr[sel_lsb +: sel_w];

  assign sel = idx;

  // anything past the last subordinate is answered by the router itself
  assign dec_err = (idx >= sel_w'(num_sub));

  assign local_addr = addr[sub_addr_w-1:0];

endmodule

// File: hdl/axil_router_wr.sv
`timescale 1ns/1ps

module axil_router_wr
  import axil_router_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 rst_n,

  input  logic                                 awvalid,
  input  logic [addr_w-1:0]                    awaddr,
  output logic                                 awready,

  input  logic                                 wvalid,
  input  logic [data_w-1:0]                    wdata,
  input  logic [strb_w-1:0]                    wstrb,
  output logic                                 wready,

  output logic                                 bvalid,
  output resp_e                                bresp,
  input  logic                                 bready,

  output logic [num_sub-1:0]                   sub_awvalid,
  output logic [num_sub-1:0][sub_addr_w-1:0]   sub_awaddr,
  input  logic [num_sub-1:0]                   sub_awready,

  output logic [num_sub-1:0]                   sub_wvalid,
  output logic [num_sub-1:0][data_w-1:0]       sub_wdata,
  output logic [num_sub-1:0][strb_w-1:0]       sub_wstrb,
  input  logic [num_sub-1:0]                   sub_wready,

  input  logic [num_sub-1:0]                   sub_bvalid,
  input  logic [num_sub-1:0][1:0]              sub_bresp,
  output logic [num_sub-1:0]                   sub_bready
);

  wr_state_e             state;
  logic [sel_w-1:0]      dec_sel;
  logic                  dec_err;
  logic [sub_addr_w-1:0] dec_addr;
  logic [sel_w-1:0]      sel_q;
  logic [sub_addr_w-1:0] addr_q;
  logic [data_w-1:0]     data_q;
  logic [strb_w-1:0]     strb_q;
  resp_e                 bresp_q;
  logic                  aw_done;
  logic                  w_done;
  logic                  accept;
  logic                  aw_hs;
  logic                  w_hs;

  axil_addr_decode u_dec (
    .addr       (awaddr),
    .sel        (dec_sel),
    .dec_err    (dec_err),
    .local_addr (dec_addr)
  );

  // AW and W are only taken together
  assign accept  = (state == wr_idle) && awvalid && wvalid;
  assign awready = accept;
  assign wready  = accept;

  assign aw_hs = (state == wr_fwd) && !aw_done && sub_awready[sel_q];
  assign w_hs  = (state == wr_fwd) && !w_done && sub_wready[sel_q];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= wr_idle;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      case (state)
        wr_idle: begin
          aw_done <= 1'b0;
          w_done  <= 1'b0;
          if (accept) begin
            state <= dec_err ? wr_resp : wr_fwd;
          end
        end
        wr_fwd: begin
          aw_done <= aw_done | aw_hs;
          w_done  <= w_done | w_hs;
          if ((aw_done || aw_hs) && (w_done || w_hs)) begin
            state <= wr_wait_b;
          end
        end
        wr_wait_b: begin
          if (sub_bvalid[sel_q]) begin
            state <= wr_resp;
          end
        end
        wr_resp: begin
          if (bready) begin
            state <= wr_idle;
          end
        end
        default: state <= wr_idle;
      endcase
    end
  end

  // request payload and the response beat
  always_ff @(posedge clk) begin
    if (accept) begin
      sel_q   <= dec_sel;
      addr_q  <= dec_addr;
      data_q  <= wdata;
      strb_q  <= wstrb;
      bresp_q <= resp_decerr;
    end else if (state == wr_wait_b && sub_bvalid[sel_q]) begin
      bresp_q <= resp_e'(sub_bresp[sel_q]);
    end
  end

  // fan-out: payload goes to every port, only the selected one sees valid
  always_comb begin
    sub_awvalid = '0;
    sub_wvalid  = '0;
    sub_bready  = '0;
    for (int i = 0; i < num_sub; i++) begin
      sub_awaddr[i] = addr_q;
      sub_wdata[i]  = data_q;
      sub_wstrb[i]  = strb_q;
    end
    if (state == wr_fwd) begin
      sub_awvalid[sel_q] = !aw_done;
      sub_wvalid[sel_q]  = !w_done;
    end
    if (state == wr_wait_b) begin
      sub_bready[sel_q] = 1'b1;
    end
  end

  assign bvalid = (state == wr_resp);
  assign bresp  = bresp_q;

  sub_aw_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(sub_awvalid) && $onehot0(sub_wvalid));

  bvalid_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid && $stable(bresp));

  idle_quiet_a: assert property (@(posedge clk) disable iff (!rst_n)
    state == wr_idle |-> (sub_awvalid == '0) && (sub_wvalid == '0));

endmodule

// File: hdl/axil_router_rd.sv
`timescale 1ns/1ps

module axil_router_rd
  import axil_router_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 rst_n,

  input  logic                                 arvalid,
  input  logic [addr_w-1:0]                    araddr,
  output logic                                 arready,

  output logic                                 rvalid,
  output logic [data_w-1:0]                    rdata,
  output resp_e                                rresp,
  input  logic                                 rready,

  output logic [num_sub-1:0]                   sub_arvalid,
  output logic [num_sub-1:0][sub_addr_w-1:0]   sub_araddr,
  input  logic [num_sub-1:0]                   sub_arready,

  input  logic [num_sub-1:0]                   sub_rvalid,
  input  logic [num_sub-1:0][data_w-1:0]       sub_rdata,
  input  logic [num_sub-1:0][1:0]              sub_rresp,
  output logic [num_sub-1:0]                   sub_rready
);

  rd_state_e             state;
  logic [sel_w-1:0]      dec_sel;
  logic                  dec_err;
  logic [sub_addr_w-1:0] dec_addr;
  logic [sel_w-1:0]      sel_q;
  logic [sub_addr_w-1:0] addr_q;
  logic [data_w-1:0]     rdata_q;
  resp_e                 rresp_q;
  logic                  accept;
  logic                  r_hs;

  axil_addr_decode u_dec (
    .addr       (araddr),
    .sel        (dec_sel),
    .dec_err    (dec_err),
    .local_addr (dec_addr)
  );

  assign arready = (state == rd_idle);
  assign accept  = arready && arvalid;
  assign r_hs    = (state == rd_wait_r) && sub_rvalid[sel_q];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= rd_idle;
    end else begin
      case (state)
        rd_idle: begin
          if (accept) begin
            state <= dec_err ? rd_resp : rd_fwd;
          end
        end
        rd_fwd: begin
          if (sub_arready[sel_q]) begin
            state <= rd_wait_r;
          end
        end
        rd_wait_r: begin
          if (r_hs) begin
            state <= rd_resp;
          end
        end
        rd_resp: begin
          if (rready) begin
            state <= rd_idle;
          end
        end
        default: state <= rd_idle;
      endcase
    end
  end

  // unmapped reads get zero data with DECERR, otherwise the R beat is captured
  always_ff @(posedge clk) begin
    if (accept) begin
      sel_q   <= dec_sel;
      addr_q  <= dec_addr;
      rdata_q <= '0;
      rresp_q <= resp_decerr;
    end else if (r_hs) begin
      rdata_q <= sub_rdata[sel_q];
      rresp_q <= resp_e'(sub_rresp[sel_q]);
    end
  end

  always_comb begin
    sub_arvalid = '0;
    sub_rready  = '0;
    for (int i = 0; i < num_sub; i++) begin
      sub_araddr[i] = addr_q;
    end
    if (state == rd_fwd) begin
      sub_arvalid[sel_q] = 1'b1;
    end
    if (state == rd_wait_r) begin
      sub_rready[sel_q] = 1'b1;
    end
  end

  assign rvalid = (state == rd_resp);
  assign rdata  = rdata_q;
  assign rresp  = rresp_q;

  sub_ar_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(sub_arvalid));

  rvalid_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

// File: hdl/axil_router.sv
`timescale 1ns/1ps

module axil_router
  import axil_router_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 rst_n,

  // manager port
  input  logic                                 awvalid,
  input  logic [addr_w-1:0]                    awaddr,
  output logic                                 awready,

  input  logic                                 wvalid,
  input  logic [data_w-1:0]                    wdata,
  input  logic [strb_w-1:0]                    wstrb,
  output logic                                 wready,

  output logic                                 bvalid,
  output resp_e                                bresp,
  input  logic                                 bready,

  input  logic                                 arvalid,
  input  logic [addr_w-1:0]                    araddr,
  output logic                                 arready,

  output logic                                 rvalid,
  output logic [data_w-1:0]                    rdata,
  output resp_e                                rresp,
  input  logic                                 rready,

  // subordinate ports, one slot per subordinate
  output logic [num_sub-1:0]                   sub_awvalid,
  output logic [num_sub-1:0][sub_addr_w-1:0]   sub_awaddr,
  input  logic [num_sub-1:0]                   sub_awready,

  output logic [num_sub-1:0]                   sub_wvalid,
  output logic [num_sub-1:0][data_w-1:0]       sub_wdata,
  output logic [num_sub-1:0][strb_w-1:0]       sub_wstrb,
  input  logic [num_sub-1:0]                   sub_wready,

  input  logic [num_sub-1:0]                   sub_bvalid,
  input  logic [num_sub-1:0][1:0]              sub_bresp,
  output logic [num_sub-1:0]                   sub_bready,

  output logic [num_sub-1:0]                   sub_arvalid,
  output logic [num_sub-1:0][sub_addr_w-1:0]   sub_araddr,
  input  logic [num_sub-1:0]                   sub_arready,

  input  logic [num_sub-1:0]                   sub_rvalid,
  input  logic [num_sub-1:0][data_w-1:0]       sub_rdata,
  input  logic [num_sub-1:0][1:0]              sub_rresp,
  output logic [num_sub-1:0]                   sub_rready
);

  // read and write paths run independently, each with its own decoder
  axil_router_wr u_wr (
    .*
  );

  axil_router_rd u_rd (
    .*
  );

endmodule

// File: dv/axil_sub_model.sv
`timescale 1ns/1ps

module axil_sub_model
  import axil_router_pkg::*;
#(
  parameter int idx = 0
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  awvalid,
  input  logic [sub_addr_w-1:0] awaddr,
  output logic                  awready,
  input  logic                  wvalid,
  input  logic [data_w-1:0]     wdata,
  input  logic [strb_w-1:0]     wstrb,
  output logic                  wready,
  output logic                  bvalid,
  output logic [1:0]            bresp,
  input  logic                  bready,
  input  logic                  arvalid,
  input  logic [sub_addr_w-1:0] araddr,
  output logic                  arready,
  output logic                  rvalid,
  output logic [data_w-1:0]     rdata,
  output logic [1:0]            rresp,
  input  logic                  rready,
  output logic [sub_addr_w-1:0] last_addr
);

  logic [data_w-1:0]     mem [16];
  int unsigned           aw_cnt;
  int unsigned           w_cnt;
  int unsigned           ar_cnt;
  int unsigned           b_cnt;
  int unsigned           r_cnt;
  logic                  aw_got;
  logic                  w_got;
  logic                  ar_got;
  logic [sub_addr_w-1:0] aw_q;
  logic [sub_addr_w-1:0] ar_q;
  logic [data_w-1:0]     w_q;
  logic [strb_w-1:0]     s_q;

  // each ready comes up once its random wait has counted down
  assign awready = awvalid && !aw_got && (aw_cnt == 0);
  assign wready  = wvalid && !w_got && (w_cnt == 0);
  assign arready = arvalid && !ar_got && (ar_cnt == 0);

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) begin
        mem[i] <= 32'h5A00_0000 + idx * 256 + i;
      end
      {aw_got, w_got, ar_got, bvalid, rvalid} <= '0;
      bresp     <= resp_okay;
      rresp     <= resp_okay;
      rdata     <= '0;
      last_addr <= '0;
      aw_cnt    <= $urandom % 4;
      w_cnt     <= $urandom % 4;
      ar_cnt    <= $urandom % 4;
      b_cnt     <= $urandom % 4;
      r_cnt     <= $urandom % 4;
    end else begin
      if (awvalid && awready) begin
        aw_got    <= 1'b1;
        aw_q      <= awaddr;
        last_addr <= awaddr;
        aw_cnt    <= $urandom % 4;
      end else if (awvalid && aw_cnt != 0) begin
        aw_cnt <= aw_cnt - 1;
      end
      if (wvalid && wready) begin
        w_got <= 1'b1;
        w_q   <= wdata;
        s_q   <= wstrb;
        w_cnt <= $urandom % 4;
      end else if (wvalid && w_cnt != 0) begin
        w_cnt <= w_cnt - 1;
      end
      // write lands in memory when the B beat is raised
      if (aw_got && w_got && !bvalid) begin
        if (b_cnt == 0) begin
          for (int b = 0; b < strb_w; b++) begin
            if (s_q[b]) begin
              mem[aw_q[5:2]][8*b +: 8] <= w_q[8*b +: 8];
            end
          end
          bvalid <= 1'b1;
          bresp  <= resp_okay;
        end else begin
          b_cnt <= b_cnt - 1;
        end
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
        aw_got <= 1'b0;
        w_got  <= 1'b0;
        b_cnt  <= $urandom % 4;
      end
      if (arvalid && arready) begin
        ar_got    <= 1'b1;
        ar_q      <= araddr;
        last_addr <= araddr;
        ar_cnt    <= $urandom % 4;
      end else if (arvalid && ar_cnt != 0) begin
        ar_cnt <= ar_cnt - 1;
      end
      if (ar_got && !rvalid) begin
        if (r_cnt == 0) begin
          rvalid <= 1'b1;
          rdata  <= mem[ar_q[5:2]];
          rresp  <= resp_okay;
        end else begin
          r_cnt <= r_cnt - 1;
        end
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
        ar_got <= 1'b0;
        r_cnt  <= $urandom % 4;
      end
    end
  end

endmodule

// File: dv/axil_router_tb.sv
`timescale 1ns/1ps

module axil_router_tb
  import axil_router_pkg::*;
();

  typedef enum logic {op_rd, op_wr} op_e;

  localparam int num_rows = 20;

  logic clk = 1'b0;
  logic rst_n;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [addr_w-1:0] awaddr, araddr;
  logic [data_w-1:0] wdata, rdata;
  logic [strb_w-1:0] wstrb;
  resp_e bresp, rresp;
  logic [num_sub-1:0] sub_awvalid, sub_awready, sub_wvalid, sub_wready;
  logic [num_sub-1:0] sub_bvalid, sub_bready, sub_arvalid, sub_arready;
  logic [num_sub-1:0] sub_rvalid, sub_rready;
  logic [num_sub-1:0][sub_addr_w-1:0] sub_awaddr, sub_araddr, seen_addr;
  logic [num_sub-1:0][data_w-1:0] sub_wdata, sub_rdata;
  logic [num_sub-1:0][strb_w-1:0] sub_wstrb;
  logic [num_sub-1:0][1:0] sub_bresp, sub_rresp;

  // stimulus table and the expected response of each row
  op_e               t_op    [num_rows];
  logic [addr_w-1:0] t_addr  [num_rows];
  logic [data_w-1:0] t_wdata [num_rows];
  logic [strb_w-1:0] t_strb  [num_rows];
  resp_e             t_resp  [num_rows];
  logic [data_w-1:0] t_rdata [num_rows];
  logic [data_w-1:0] ref_mem [num_sub][16];
  int                n_rows;
  int                row_errors;
  int                pass_cnt;
  int                fail_cnt;
  logic              quiet;

  always #4 clk = ~clk;

  axil_router UUT (.*);

  for (genvar g = 0; g < num_sub; g++) begin : g_sub
    axil_sub_model #(.idx(g)) u_model (
      .clk(clk), .rst_n(rst_n),
      .awvalid(sub_awvalid[g]), .awaddr(sub_awaddr[g]), .awready(sub_awready[g]),
      .wvalid(sub_wvalid[g]), .wdata(sub_wdata[g]), .wstrb(sub_wstrb[g]),
      .wready(sub_wready[g]),
      .bvalid(sub_bvalid[g]), .bresp(sub_bresp[g]), .bready(sub_bready[g]),
      .arvalid(sub_arvalid[g]), .araddr(sub_araddr[g]), .arready(sub_arready[g]),
      .rvalid(sub_rvalid[g]), .rdata(sub_rdata[g]), .rresp(sub_rresp[g]),
      .rready(sub_rready[g]),
      .last_addr(seen_addr[g])
    );
  end

  // unmapped transactions must never reach a subordinate
  always @(posedge clk) begin
    if (quiet) begin
      assert (sub_awvalid == '0 && sub_wvalid == '0 && sub_arvalid == '0) else begin
        $display("a subordinate valid rose during an unmapped transaction");
        row_errors++;
      end
    end
  end

  task automatic add_row(input op_e op, input logic [addr_w-1:0] addr,
                         input logic [data_w-1:0] data, input logic [strb_w-1:0] strb);
    int s;
    int w;
    s = addr[15:14];
    w = addr[5:2];
    t_op[n_rows]    = op;
    t_addr[n_rows]  = addr;
    t_wdata[n_rows] = data;
    t_strb[n_rows]  = strb;
    t_rdata[n_rows] = '0;
    t_resp[n_rows]  = (s >= num_sub) ? resp_decerr : resp_okay;
    if (s < num_sub && op == op_wr) begin
      for (int b = 0; b < strb_w; b++) begin
        if (strb[b]) begin
          ref_mem[s][w][8*b +: 8] = data[8*b +: 8];
        end
      end
    end else if (s < num_sub) begin
      t_rdata[n_rows] = ref_mem[s][w];
    end
    n_rows++;
  endtask

  task automatic compare_value(input string name, input logic [data_w-1:0] exp,
                               input logic [data_w-1:0] got);
    assert (got === exp) else begin
      $display("Mismatch %s: expected 0x%0h observed 0x%0h", name, exp, got);
      row_errors++;
    end
  endtask

  task automatic report_test(input string name);
    $display("test %s: %s", name, (row_errors == 0) ? "ok" : "error");
    if (row_errors == 0) begin
      pass_cnt++;
    end else begin
      fail_cnt++;
    end
  endtask

  task automatic do_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                          input logic [strb_w-1:0] strb, output logic [1:0] resp);
    int hold;
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    wstrb   = strb;
    do begin
      @(posedge clk);
    end while (!awready);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) begin
      @(posedge clk);
      #1;
    end
    resp = bresp;
    hold = $urandom % 4;
    repeat (hold) begin
      @(posedge clk);
      #1;
      assert (bvalid && bresp == resp) else begin
        $display("B beat dropped or changed while bready was low");
        row_errors++;
      end
    end
    bready = 1'b1;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic do_read(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data,
                         output logic [1:0] resp);
    int hold;
    arvalid = 1'b1;
    araddr  = addr;
    do begin
      @(posedge clk);
    end while (!arready);
    #1;
    arvalid = 1'b0;
    while (!rvalid) begin
      @(posedge clk);
      #1;
    end
    data = rdata;
    resp = rresp;
    hold = $urandom % 4;
    repeat (hold) begin
      @(posedge clk);
      #1;
      assert (rvalid && rdata == data && rresp == resp) else begin
        $display("R beat dropped or changed while rready was low");
        row_errors++;
      end
    end
    rready = 1'b1;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  initial begin
    logic [1:0]        resp;
    logic [data_w-1:0] data;
    int                s;
    void'($urandom(32'h2611));
    {rst_n, awvalid, wvalid, bready, arvalid, rready, quiet} = '0;
    awaddr = '0;
    araddr = '0;
    wdata  = '0;
    wstrb  = '0;
    {n_rows, row_errors, pass_cnt, fail_cnt} = '0;
    for (int i = 0; i < num_sub; i++) begin
      for (int j = 0; j < 16; j++) begin
        ref_mem[i][j] = 32'h5A00_0000 + i * 256 + j;
      end
    end
    add_row(op_rd, 16'h0004, '0, '0);
    add_row(op_rd, 16'h4008, '0, '0);
    add_row(op_rd, 16'h803C, '0, '0);
    add_row(op_wr, 16'h0004, 32'hDEAD_BEEF, 4'hF);
    add_row(op_rd, 16'h0004, '0, '0);
    add_row(op_rd, 16'h4004, '0, '0);
    add_row(op_rd, 16'h8004, '0, '0);
    add_row(op_wr, 16'h4110, 32'h1234_5678, 4'hF);
    add_row(op_rd, 16'h4110, '0, '0);
    add_row(op_rd, 16'h0010, '0, '0);
    // partial strobes merge with what is already there
    add_row(op_wr, 16'h8008, 32'hAABB_CCDD, 4'h5);
    add_row(op_rd, 16'h8008, '0, '0);
    add_row(op_wr, 16'h0004, 32'h1122_3344, 4'h8);
    add_row(op_rd, 16'h0004, '0, '0);
    add_row(op_rd, 16'hC000, '0, '0);
    add_row(op_wr, 16'hC004, 32'hCAFE_F00D, 4'hF);
    add_row(op_rd, 16'hFFFC, '0, '0);
    add_row(op_wr, 16'hA03C, 32'h0BAD_C0DE, 4'hF);
    add_row(op_rd, 16'hA03C, '0, '0);
    add_row(op_rd, 16'h003C, '0, '0);
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    assert (sub_awvalid == '0 && sub_wvalid == '0 && sub_arvalid == '0 && !bvalid && !rvalid)
      else begin
        $display("a valid output was high after reset");
        row_errors++;
      end
    report_test("reset");
    for (int i = 0; i < n_rows; i++) begin
      row_errors = 0;
      s = t_addr[i][15:14];
      quiet = (s >= num_sub);
      if (t_op[i] == op_wr) begin
        do_write(t_addr[i], t_wdata[i], t_strb[i], resp);
        compare_value("bresp", t_resp[i], resp);
      end else begin
        do_read(t_addr[i], data, resp);
        compare_value("rresp", t_resp[i], resp);
        compare_value("rdata", t_rdata[i], data);
      end
      quiet = 1'b0;
      if (s < num_sub) begin
        compare_value("last_addr", t_addr[i][sub_addr_w-1:0], seen_addr[s]);
      end
      report_test($sformatf("%0d %s 0x%04h", i, t_op[i].name(), t_addr[i]));
    end
    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // budget of 40 cycles per row on top of the reset
  initial begin
    repeat (num_rows * 40 + 10) @(posedge clk);
    $display("run timed out before all table rows completed");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: all.f
hdl/axil_router_pkg.sv
hdl/axil_addr_decode.sv
hdl/axil_router_wr.sv
hdl/axil_router_rd.sv
hdl/axil_router.sv
dv/axil_sub_model.sv
dv/axil_router_tb.sv

// File: Bender.yml
package:
  name: axil_router

sources:
  - hdl/axil_router_pkg.sv
  - hdl/axil_addr_decode.sv
  - hdl/axil_router_wr.sv
  - hdl/axil_router_rd.sv
  - hdl/axil_router.sv
  - target: simulation
    files:
      - dv/axil_sub_model.sv
      - dv/axil_router_tb.sv
